// File: jpeg_front_pkg.sv
/*
 * JPEG encoder front end shared definitions
 * Sample and counter types, sensor limits and the fixed-point
 * RGB to YCbCr conversion matrix
 */
`default_nettype none

package jpeg_front_pkg;

    // ************************************************************************
    // Sensor limits
    // ************************************************************************

    // Largest frame that the counters and the chroma line buffer can hold
    localparam int SENSOR_X_SIZE = 720;
    localparam int SENSOR_Y_SIZE = 720;

    localparam int SAMPLE_W      = 8;
    localparam int PIXEL_COUNT_W = $clog2(SENSOR_X_SIZE);
    localparam int LINE_COUNT_W  = $clog2(SENSOR_Y_SIZE);

    // One stored chroma pair sum for every two pixels of an even line
    localparam int CHROMA_BUF_SIZE = SENSOR_X_SIZE / 2;

    typedef logic [SAMPLE_W-1:0]      sample_t;
    typedef logic [PIXEL_COUNT_W-1:0] pixel_count_t;
    typedef logic [LINE_COUNT_W-1:0]  line_count_t;
    typedef logic [SAMPLE_W:0]        chroma_sum_t;
    typedef logic signed [8:0]        coef_t;

    // ************************************************************************
    // Color conversion, coefficients scaled by 2**COEF_FRAC_W
    // ************************************************************************

    localparam int COEF_FRAC_W = 8;

    localparam coef_t COEF_YR  =  9'sd77;
    localparam coef_t COEF_YG  =  9'sd150;
    localparam coef_t COEF_YB  =  9'sd29;
    localparam coef_t COEF_CBR = -9'sd43;
    localparam coef_t COEF_CBG = -9'sd85;
    localparam coef_t COEF_CBB =  9'sd128;
    localparam coef_t COEF_CRR =  9'sd128;
    localparam coef_t COEF_CRG = -9'sd107;
    localparam coef_t COEF_CRB = -9'sd21;

    // Mid-scale offset so that Cb and Cr are unsigned
    localparam int CHROMA_OFFSET = 128;

endpackage

`default_nettype wire

// File: color_convert.sv
/*
 * RGB to YCbCr color conversion
 * Two-stage fixed-point pipeline: products, then row sums with
 * rounding, chroma offset and clamping. Framing travels beside
 * the data and the whole stage stalls while hold is high.
 */
`timescale 1ns/1ps
`default_nettype none

module color_convert (
    input  logic                    clk,
    input  logic                    resetn,
    input  jpeg_front_pkg::sample_t r_in,
    input  jpeg_front_pkg::sample_t g_in,
    input  jpeg_front_pkg::sample_t b_in,
    input  logic                    pixel_valid_in,
    input  logic                    frame_valid_in,
    input  logic                    line_valid_in,
    input  logic                    hold,
    output jpeg_front_pkg::sample_t y,
    output jpeg_front_pkg::sample_t cb,
    output jpeg_front_pkg::sample_t cr,
    output logic                    valid,
    output logic                    frame_valid,
    output logic                    line_valid
);
    import jpeg_front_pkg::*;

    // Signed coefficient times zero-extended sample
    typedef logic signed [17:0] product_t;
    // Three products plus rounding and offset with headroom
    typedef logic signed [19:0] acc_t;

    localparam acc_t ROUND_BIAS = acc_t'(1 << (COEF_FRAC_W - 1));

    // Index 0 is the R term, 1 is G, 2 is B
    product_t prod_y  [3];
    product_t prod_cb [3];
    product_t prod_cr [3];

    logic valid_s1;
    logic frame_valid_s1;
    logic line_valid_s1;

    acc_t y_sum;
    acc_t cb_sum;
    acc_t cr_sum;
    acc_t y_scaled;
    acc_t cb_scaled;
    acc_t cr_scaled;

    function automatic product_t mul(input coef_t coef, input sample_t sample);
        return coef * $signed({1'b0, sample});
    endfunction

    function automatic sample_t clamp_sample(input acc_t value);
        sample_t result;
        if (value < 0) begin
            result = '0;
        end else if (value > 255) begin
            result = '1;
        end else begin
            result = value[SAMPLE_W-1:0];
        end
        return result;
    endfunction

    // ************************************************************************
    // Stage 1: nine products
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!hold) begin
            prod_y[0]  <= mul(COEF_YR, r_in);
            prod_y[1]  <= mul(COEF_YG, g_in);
            prod_y[2]  <= mul(COEF_YB, b_in);
            prod_cb[0] <= mul(COEF_CBR, r_in);
            prod_cb[1] <= mul(COEF_CBG, g_in);
            prod_cb[2] <= mul(COEF_CBB, b_in);
            prod_cr[0] <= mul(COEF_CRR, r_in);
            prod_cr[1] <= mul(COEF_CRG, g_in);
            prod_cr[2] <= mul(COEF_CRB, b_in);
        end
    end

    // ************************************************************************
    // Stage 2: row sums, rounding, offset and clamp
    // ************************************************************************

    always_comb begin
        y_sum  = acc_t'(prod_y[0]) + acc_t'(prod_y[1]) + acc_t'(prod_y[2]) + ROUND_BIAS;
        cb_sum = acc_t'(prod_cb[0]) + acc_t'(prod_cb[1]) + acc_t'(prod_cb[2]) + ROUND_BIAS;
        cr_sum = acc_t'(prod_cr[0]) + acc_t'(prod_cr[1]) + acc_t'(prod_cr[2]) + ROUND_BIAS;

        // Arithmetic shift keeps negative chroma terms negative before the offset
        y_scaled  = y_sum >>> COEF_FRAC_W;
        cb_scaled = (cb_sum >>> COEF_FRAC_W) + acc_t'(CHROMA_OFFSET);
        cr_scaled = (cr_sum >>> COEF_FRAC_W) + acc_t'(CHROMA_OFFSET);
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            y  <= clamp_sample(y_scaled);
            cb <= clamp_sample(cb_scaled);
            cr <= clamp_sample(cr_scaled);
        end
    end

    // Valid and framing, two deep to match the data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_s1       <= 1'b0;
            frame_valid_s1 <= 1'b0;
            line_valid_s1  <= 1'b0;
            valid          <= 1'b0;
            frame_valid    <= 1'b0;
            line_valid     <= 1'b0;
        end else if (!hold) begin
            valid_s1       <= pixel_valid_in;
            frame_valid_s1 <= frame_valid_in;
            line_valid_s1  <= line_valid_in;
            valid          <= valid_s1;
            frame_valid    <= frame_valid_s1;
            line_valid     <= line_valid_s1;
        end
    end

    // Pixels only arrive inside a line, so none may leave outside one
    assert property (@(posedge clk) disable iff (!resetn) valid |-> line_valid)
        else $error("color_convert: valid high while line_valid is low");

endmodule

`default_nettype wire

// File: chroma_subsample.sv
/*
 * 4:4:4 to 4:2:0 chroma subsampling
 * Even lines store horizontal chroma pair sums in a half-line buffer,
 * odd lines add them to the current pair and emit the rounded 2x2
 * average. Also forms eol/eof pulses and the sample position.
 */
`timescale 1ns/1ps
`default_nettype none

module chroma_subsample (
    input  logic                         clk,
    input  logic                         resetn,
    input  jpeg_front_pkg::sample_t      y_in,
    input  jpeg_front_pkg::sample_t      cb_in,
    input  jpeg_front_pkg::sample_t      cr_in,
    input  logic                         valid_in,
    input  logic                         frame_valid_in,
    input  logic                         line_valid_in,
    input  logic                         hold_in,
    output logic                         hold_out,
    output jpeg_front_pkg::sample_t      y_out,
    output jpeg_front_pkg::sample_t      cb_out,
    output jpeg_front_pkg::sample_t      cr_out,
    output logic                         y_valid,
    output logic                         chroma_valid,
    output logic                         frame_valid_out,
    output logic                         line_valid_out,
    output logic                         eol_out,
    output logic                         eof_out,
    output jpeg_front_pkg::pixel_count_t pixel_pos,
    output jpeg_front_pkg::line_count_t  line_pos
);
    import jpeg_front_pkg::*;

    // Buffered pair sum plus the current pair plus rounding
    typedef logic [SAMPLE_W+1:0] quad_sum_t;

    logic eol;
    logic eof;
    logic accept;
    logic eol_d;
    logic eof_d;
    logic odd_pixel;
    logic odd_line;

    pixel_count_t pixel_count;
    line_count_t  line_count;

    logic [PIXEL_COUNT_W-2:0] buf_idx;

    // Chroma of the even pixel of the current pair
    sample_t cb_first;
    sample_t cr_first;

    chroma_sum_t cb_line_buf [CHROMA_BUF_SIZE];
    chroma_sum_t cr_line_buf [CHROMA_BUF_SIZE];

    quad_sum_t cb_quad_sum;
    quad_sum_t cr_quad_sum;

    always_comb hold_out = hold_in;

    // Falling edges, seen against the registered framing levels
    always_comb begin
        eol    = line_valid_out & ~line_valid_in;
        eof    = frame_valid_out & ~frame_valid_in;
        accept = valid_in & line_valid_in & ~hold_in;
    end

    always_comb begin
        odd_pixel = pixel_count[0];
        odd_line  = line_count[0];
        buf_idx   = pixel_count[PIXEL_COUNT_W-1:1];
    end

    // ************************************************************************
    // Position counters
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pixel_count <= '0;
            line_count  <= '0;
        end else if (!hold_in) begin
            if (eof) begin
                pixel_count <= '0;
                line_count  <= '0;
            end else if (eol) begin
                pixel_count <= '0;
                line_count  <= line_count + 1'b1;
            end else if (accept) begin
                pixel_count <= pixel_count + 1'b1;
            end
        end
    end

    // ************************************************************************
    // Chroma line buffer and averaging
    // ************************************************************************

    always_comb begin
        cb_quad_sum = quad_sum_t'(cb_line_buf[buf_idx]) + quad_sum_t'(cb_first)
                    + quad_sum_t'(cb_in) + quad_sum_t'(2);
        cr_quad_sum = quad_sum_t'(cr_line_buf[buf_idx]) + quad_sum_t'(cr_first)
                    + quad_sum_t'(cr_in) + quad_sum_t'(2);
    end

    // Even line, odd pixel: store the horizontal pair sum
    always_ff @(posedge clk) begin
        if (accept && odd_pixel && !odd_line) begin
            cb_line_buf[buf_idx] <= chroma_sum_t'(cb_first) + chroma_sum_t'(cb_in);
            cr_line_buf[buf_idx] <= chroma_sum_t'(cr_first) + chroma_sum_t'(cr_in);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            y_out     <= y_in;
            pixel_pos <= pixel_count;
            line_pos  <= line_count;
            if (!odd_pixel) begin
                cb_first <= cb_in;
                cr_first <= cr_in;
            end else if (odd_line) begin
                // Divide by four, rounding half up
                cb_out <= cb_quad_sum[SAMPLE_W+1:2];
                cr_out <= cr_quad_sum[SAMPLE_W+1:2];
            end
        end
    end

    // ************************************************************************
    // Valids, framing and end pulses
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!resetn) begin
            y_valid         <= 1'b0;
            chroma_valid    <= 1'b0;
            frame_valid_out <= 1'b0;
            line_valid_out  <= 1'b0;
            eol_d           <= 1'b0;
            eof_d           <= 1'b0;
            eol_out         <= 1'b0;
            eof_out         <= 1'b0;
        end else if (!hold_in) begin
            y_valid         <= valid_in & line_valid_in;
            chroma_valid    <= valid_in & line_valid_in & odd_pixel & odd_line;
            frame_valid_out <= frame_valid_in;
            line_valid_out  <= line_valid_in;
            // Extra stage puts the pulse one cycle after line_valid_out drops
            eol_d           <= eol;
            eof_d           <= eof;
            eol_out         <= eol_d;
            eof_out         <= eof_d;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) chroma_valid |-> y_valid)
        else $error("chroma_subsample: chroma_valid without y_valid");

    assert property (@(posedge clk) disable iff (!resetn)
        (eol_out && !hold_in) |=> !eol_out)
        else $error("chroma_subsample: eol_out longer than one cycle");

    assert property (@(posedge clk) disable iff (!resetn)
        (eof_out && !hold_in) |=> !eof_out)
        else $error("chroma_subsample: eof_out longer than one cycle");

endmodule

`default_nettype wire

// File: jpeg_front_top.sv
/*
 * JPEG encoder front end
 * Color conversion followed by 4:2:0 chroma subsampling, three
 * cycles from camera pixel to encoder sample
 */
`timescale 1ns/1ps
`default_nettype none

module jpeg_front_top (
    input  logic                         clk,
    input  logic                         resetn,

    // Camera side
    input  jpeg_front_pkg::sample_t      r_in,
    input  jpeg_front_pkg::sample_t      g_in,
    input  jpeg_front_pkg::sample_t      b_in,
    input  logic                         pixel_valid_in,
    input  logic                         frame_valid_in,
    input  logic                         line_valid_in,
    output logic                         hold_out,

    // Encoder side
    output jpeg_front_pkg::sample_t      y_out,
    output jpeg_front_pkg::sample_t      cb_out,
    output jpeg_front_pkg::sample_t      cr_out,
    output logic                         y_valid,
    output logic                         chroma_valid,
    output logic                         frame_valid_out,
    output logic                         line_valid_out,
    output logic                         eol_out,
    output logic                         eof_out,
    output jpeg_front_pkg::pixel_count_t pixel_pos,
    output jpeg_front_pkg::line_count_t  line_pos,
    input  logic                         hold_in
);
    import jpeg_front_pkg::*;

    sample_t ycc_y;
    sample_t ycc_cb;
    sample_t ycc_cr;
    logic    ycc_valid;
    logic    ycc_frame_valid;
    logic    ycc_line_valid;
    logic    ycc_hold;

    color_convert color_convert_i (
        .clk            (clk),
        .resetn         (resetn),
        .r_in           (r_in),
        .g_in           (g_in),
        .b_in           (b_in),
        .pixel_valid_in (pixel_valid_in),
        .frame_valid_in (frame_valid_in),
        .line_valid_in  (line_valid_in),
        .hold           (ycc_hold),
        .y              (ycc_y),
        .cb             (ycc_cb),
        .cr             (ycc_cr),
        .valid          (ycc_valid),
        .frame_valid    (ycc_frame_valid),
        .line_valid     (ycc_line_valid)
    );

    chroma_subsample chroma_subsample_i (
        .clk             (clk),
        .resetn          (resetn),
        .y_in            (ycc_y),
        .cb_in           (ycc_cb),
        .cr_in           (ycc_cr),
        .valid_in        (ycc_valid),
        .frame_valid_in  (ycc_frame_valid),
        .line_valid_in   (ycc_line_valid),
        .hold_in         (hold_in),
        .hold_out        (ycc_hold),
        .y_out           (y_out),
        .cb_out          (cb_out),
        .cr_out          (cr_out),
        .y_valid         (y_valid),
        .chroma_valid    (chroma_valid),
        .frame_valid_out (frame_valid_out),
        .line_valid_out  (line_valid_out),
        .eol_out         (eol_out),
        .eof_out         (eof_out),
        .pixel_pos       (pixel_pos),
        .line_pos        (line_pos)
    );

    // Back-pressure reaches the camera with no register in the path
    assign hold_out = ycc_hold;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * 20 ns clock, resetn held low for the first two rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_jpeg_front.sv
/*
 * Testbench for the JPEG encoder front end
 * Drives 8x4 frames of gray and random pixels, with and without
 * back-pressure, and checks samples, chroma, framing and hold
 */
`timescale 1ns/1ps
`default_nettype none

module tb_jpeg_front;
    import jpeg_front_pkg::*;

    localparam int FRAME_W      = 8;
    localparam int FRAME_H      = 4;
    localparam int LINE_GAP     = 3;
    localparam int FRAME_CYCLES = 2 + FRAME_H * (FRAME_W + LINE_GAP) + 3;
    localparam int NUM_FRAMES   = 5;
    localparam int TIMEOUT      = 2 * FRAME_CYCLES * NUM_FRAMES + 200;
    localparam int CHROMA_PER_FRAME = (FRAME_W / 2) * (FRAME_H / 2);

    typedef struct packed {
        sample_t      y;
        sample_t      cb;
        sample_t      cr;
        logic         chroma;
        pixel_count_t px;
        line_count_t  ln;
        int           cycle;
    } expected_t;

    logic         clk;
    logic         resetn;
    sample_t      r_in;
    sample_t      g_in;
    sample_t      b_in;
    logic         pixel_valid_in;
    logic         frame_valid_in;
    logic         line_valid_in;
    logic         hold_out;
    sample_t      y_out;
    sample_t      cb_out;
    sample_t      cr_out;
    logic         y_valid;
    logic         chroma_valid;
    logic         frame_valid_out;
    logic         line_valid_out;
    logic         eol_out;
    logic         eof_out;
    pixel_count_t pixel_pos;
    line_count_t  line_pos;
    logic         hold_in;

    int          cycle = 0;
    int          error_count = 0;
    int          sample_count = 0;
    int          test_count = 0;
    int          eol_count = 0;
    int          eof_count = 0;
    int          chroma_count = 0;
    logic [31:0] lcg_state = 32'd94456;
    bit          hold_enable = 1'b0;
    bit          gray_mode = 1'b0;

    sample_t     frame_r [FRAME_H][FRAME_W];
    sample_t     frame_g [FRAME_H][FRAME_W];
    sample_t     frame_b [FRAME_H][FRAME_W];
    int          model_cb [FRAME_H][FRAME_W];
    int          model_cr [FRAME_H][FRAME_W];
    expected_t   expected [$];

    tb_clock_gen tb_clock_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    jpeg_front_top jpeg_front_top_i (
        .clk             (clk),
        .resetn          (resetn),
        .r_in            (r_in),
        .g_in            (g_in),
        .b_in            (b_in),
        .pixel_valid_in  (pixel_valid_in),
        .frame_valid_in  (frame_valid_in),
        .line_valid_in   (line_valid_in),
        .hold_out        (hold_out),
        .y_out           (y_out),
        .cb_out          (cb_out),
        .cr_out          (cr_out),
        .y_valid         (y_valid),
        .chroma_valid    (chroma_valid),
        .frame_valid_out (frame_valid_out),
        .line_valid_out  (line_valid_out),
        .eol_out         (eol_out),
        .eof_out         (eof_out),
        .pixel_pos       (pixel_pos),
        .line_pos        (line_pos),
        .hold_in         (hold_in)
    );

    // ************************************************************************
    // Helpers and reference model
    // ************************************************************************

    function automatic void report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // One row of the matrix at scale 256 with round half up and clamp
    function automatic int convert(input int c_r, input int c_g, input int c_b,
                                   input int r, input int g, input int b,
                                   input int offset);
        int acc;
        acc = ((c_r * r + c_g * g + c_b * b + 128) >>> 8) + offset;
        if (acc < 0) begin
            acc = 0;
        end else if (acc > 255) begin
            acc = 255;
        end
        return acc;
    endfunction

    task automatic push_expected(input int ln, input int px, input int accept_cycle);
        expected_t e;
        int r;
        int g;
        int b;
        r = int'(frame_r[ln][px]);
        g = int'(frame_g[ln][px]);
        b = int'(frame_b[ln][px]);
        if (gray_mode) begin
            // Gray input gives Y equal to the level and neutral chroma
            e.y = frame_r[ln][px];
            model_cb[ln][px] = 128;
            model_cr[ln][px] = 128;
        end else begin
            e.y = sample_t'(convert(COEF_YR, COEF_YG, COEF_YB, r, g, b, 0));
            model_cb[ln][px] = convert(COEF_CBR, COEF_CBG, COEF_CBB, r, g, b, CHROMA_OFFSET);
            model_cr[ln][px] = convert(COEF_CRR, COEF_CRG, COEF_CRB, r, g, b, CHROMA_OFFSET);
        end
        e.chroma = (ln % 2 == 1) && (px % 2 == 1);
        e.cb = '0;
        e.cr = '0;
        if (e.chroma) begin
            e.cb = sample_t'((model_cb[ln-1][px-1] + model_cb[ln-1][px]
                            + model_cb[ln][px-1] + model_cb[ln][px] + 2) >> 2);
            e.cr = sample_t'((model_cr[ln-1][px-1] + model_cr[ln-1][px]
                            + model_cr[ln][px-1] + model_cr[ln][px] + 2) >> 2);
        end
        e.px = pixel_count_t'(px);
        e.ln = line_count_t'(ln);
        e.cycle = accept_cycle;
        expected.push_back(e);
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    // Present one camera cycle and repeat it until an edge with hold low takes it
    task automatic drive_cycle(input logic fv, input logic lv, input logic pv,
                               input sample_t r, input sample_t g, input sample_t b,
                               output int accept_cycle);
        logic        accepted;
        logic [31:0] rnd;
        frame_valid_in <= fv;
        line_valid_in  <= lv;
        pixel_valid_in <= pv;
        r_in           <= r;
        g_in           <= g;
        b_in           <= b;
        accepted = 1'b0;
        accept_cycle = 0;
        while (!accepted) begin
            @(posedge clk);
            accepted = !hold_in;
            accept_cycle = cycle;
            rnd = next_random();
            hold_in <= hold_enable && (rnd[31:24] < 8'd85);
        end
    endtask

    task automatic idle_cycle(input logic fv);
        int unused_cycle;
        drive_cycle(fv, 1'b0, 1'b0, '0, '0, '0, unused_cycle);
    endtask

    task automatic fill_gray_frame();
        for (int ln = 0; ln < FRAME_H; ln++) begin
            for (int px = 0; px < FRAME_W; px++) begin
                frame_r[ln][px] = sample_t'(((ln * FRAME_W + px) * 255) / (FRAME_W * FRAME_H - 1));
                frame_g[ln][px] = frame_r[ln][px];
                frame_b[ln][px] = frame_r[ln][px];
            end
        end
    endtask

    task automatic fill_random_frame();
        logic [31:0] rnd;
        for (int ln = 0; ln < FRAME_H; ln++) begin
            for (int px = 0; px < FRAME_W; px++) begin
                rnd = next_random();
                frame_r[ln][px] = rnd[31:24];
                frame_g[ln][px] = rnd[23:16];
                frame_b[ln][px] = rnd[15:8];
            end
        end
    endtask

    task automatic run_frame();
        int accept_cycle;
        int eof_target;
        eof_target = eof_count + 1;
        repeat (2) idle_cycle(1'b1);
        for (int ln = 0; ln < FRAME_H; ln++) begin
            for (int px = 0; px < FRAME_W; px++) begin
                drive_cycle(1'b1, 1'b1, 1'b1, frame_r[ln][px], frame_g[ln][px],
                            frame_b[ln][px], accept_cycle);
                push_expected(ln, px, accept_cycle);
            end
            repeat (LINE_GAP) idle_cycle(1'b1);
        end
        repeat (3) idle_cycle(1'b0);
        while (eof_count < eof_target) begin
            idle_cycle(1'b0);
        end
    endtask

    task automatic run_test(input string name, input int frames);
        int errors_before;
        int eol_before;
        int eof_before;
        int chroma_before;
        errors_before = error_count;
        eol_before = eol_count;
        eof_before = eof_count;
        chroma_before = chroma_count;
        repeat (frames) run_frame();
        // Let the last counter updates land
        idle_cycle(1'b0);
        assert (expected.size() == 0)
            else report_mismatch($sformatf("%0d samples never came out", expected.size()));
        assert (eol_count - eol_before == FRAME_H * frames)
            else report_mismatch($sformatf("%0d eol pulses", eol_count - eol_before));
        assert (eof_count - eof_before == frames)
            else report_mismatch($sformatf("%0d eof pulses", eof_count - eof_before));
        assert (chroma_count - chroma_before == CHROMA_PER_FRAME * frames)
            else report_mismatch($sformatf("%0d chroma samples", chroma_count - chroma_before));
        test_count++;
        $display("Test %-16s %0d errors", name, error_count - errors_before);
    endtask

    // ************************************************************************
    // Output monitor
    // ************************************************************************

    task automatic check_sample();
        expected_t e;
        if (expected.size() == 0) begin
            error_count++;
            $display("Unexpected output at %0t: y_valid with no sample left to expect", $time);
            return;
        end
        e = expected.pop_front();
        sample_count++;
        assert (y_out == e.y)
            else report_mismatch($sformatf("y_out %0d, expected %0d", y_out, e.y));
        assert (pixel_pos == e.px && line_pos == e.ln)
            else report_mismatch($sformatf("position %0d,%0d, expected %0d,%0d",
                                           pixel_pos, line_pos, e.px, e.ln));
        assert (chroma_valid == e.chroma)
            else report_mismatch($sformatf("chroma_valid %0b, expected %0b", chroma_valid, e.chroma));
        // Framing levels run three cycles behind the camera, as the pixels do
        assert (frame_valid_out && line_valid_out)
            else report_mismatch("y_valid outside the output frame or line");
        if (e.chroma) begin
            assert (cb_out == e.cb && cr_out == e.cr)
                else report_mismatch($sformatf("cb/cr %0d/%0d, expected %0d/%0d",
                                               cb_out, cr_out, e.cb, e.cr));
        end
        if (!hold_enable) begin
            assert (cycle - e.cycle == 3)
                else report_mismatch($sformatf("latency %0d cycles", cycle - e.cycle));
        end
    endtask

    // A sample or pulse is taken on an edge where hold_in is low
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (resetn && !hold_in) begin
            if (eol_out) begin
                eol_count <= eol_count + 1;
            end
            if (eof_out) begin
                eof_count <= eof_count + 1;
            end
            if (chroma_valid) begin
                chroma_count <= chroma_count + 1;
            end
            if (y_valid) begin
                check_sample();
            end
        end
        if (cycle >= TIMEOUT) begin
            $display("Timeout: no end of tests after %0d cycles", cycle);
            $display("Finished with errors");
            $finish;
        end
    end

    assert property (@(posedge clk) hold_out == hold_in)
        else report_mismatch("hold_out differs from hold_in");

    assert property (@(posedge clk) disable iff (!resetn)
        hold_in |=> $stable({y_out, cb_out, cr_out, y_valid, chroma_valid, frame_valid_out,
                             line_valid_out, eol_out, eof_out, pixel_pos, line_pos}))
        else report_mismatch("outputs changed while hold_in was high");

    assert property (@(posedge clk) disable iff (!resetn)
        chroma_valid |-> (pixel_pos[0] && line_pos[0]))
        else report_mismatch("chroma_valid outside an odd pixel of an odd line");

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        r_in = '0;
        g_in = '0;
        b_in = '0;
        pixel_valid_in = 1'b0;
        frame_valid_in = 1'b0;
        line_valid_in = 1'b0;
        hold_in = 1'b0;

        wait (resetn === 1'b1);
        @(posedge clk);
        assert (!y_valid && !chroma_valid && !eol_out && !eof_out
                && !frame_valid_out && !line_valid_out)
            else report_mismatch("outputs not low after reset");
        test_count++;
        $display("Test %-16s %0d errors", "reset", error_count);

        gray_mode = 1'b1;
        fill_gray_frame();
        run_test("gray frame", 1);

        gray_mode = 1'b0;
        fill_random_frame();
        run_test("random frame", 1);
        run_test("repeated frame", 1);

        hold_enable = 1'b1;
        fill_random_frame();
        run_test("back-pressure", 2);

        $display("Summary: %0d tests, %0d samples checked, %0d errors",
                 test_count, sample_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
jpeg_front_pkg.sv
color_convert.sv
chroma_subsample.sv
jpeg_front_top.sv
tb_clock_gen.sv
tb_jpeg_front.sv

// File: run_sim.sh
#!/bin/sh
# Build the JPEG front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_jpeg_front \
    --Mdir obj_dir -o sim_jpeg_front \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_jpeg_front)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
